//--- common/soc_pkg.sv
package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    // any set lane marks a write
    typedef logic [3:0]  strb_t;

    typedef struct packed {
        addr_t addr;
        data_t wdata;
        strb_t wstrb;
    } bus_req_t;

    // one-hot target select
    typedef logic [4:0] dev_sel_t;

    localparam int SEL_BRAM     = 0;
    localparam int SEL_UART     = 1;
    localparam int SEL_TIMER    = 2;
    localparam int SEL_SYSINFO  = 3;
    localparam int SEL_UNMAPPED = 4;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

    ////////////////////////////////////////
    // address map
    ////////////////////////////////////////
    localparam addr_t BRAM_BASE      = 32'h0000_0000;
    localparam addr_t UART_DATA_ADDR = 32'h1000_0000;
    localparam addr_t UART_LSR_ADDR  = 32'h1000_0004;
    // cnt lo/hi at +0/+4, cmp lo/hi at +8/+12
    localparam addr_t TIMER_BASE     = 32'h1100_0000;
    localparam addr_t SYSINFO_ADDR   = 32'h1200_0000;

    // line status bits
    localparam int LSR_RX_READY = 0;
    localparam int LSR_OVERRUN  = 1;
    localparam int LSR_TX_EMPTY = 5;
    localparam int LSR_TX_IDLE  = 6;

endpackage

//--- logic/bus_decoder.sv
module bus_decoder #(
    parameter int BRAM_WORDS = 256
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              valid,
    input  soc_pkg::bus_req_t req,
    input  logic              ready,
    output soc_pkg::dev_sel_t sel,
    output logic              bram_valid,
    output logic              uart_valid,
    output logic              timer_valid,
    output logic              sysinfo_valid,
    output logic              unmapped_valid
);

    localparam soc_pkg::addr_t BRAM_BYTES = soc_pkg::addr_t'(BRAM_WORDS * 4);

    logic is_bram;
    logic is_uart;
    logic is_timer;
    logic is_sysinfo;
    logic strobe;

    assign is_bram    = (req.addr - soc_pkg::BRAM_BASE) < BRAM_BYTES;
    assign is_uart    = (req.addr == soc_pkg::UART_DATA_ADDR) ||
                        (req.addr == soc_pkg::UART_LSR_ADDR);
    // 16-byte timer window
    assign is_timer   = (req.addr[31:4] == soc_pkg::TIMER_BASE[31:4]);
    assign is_sysinfo = (req.addr == soc_pkg::SYSINFO_ADDR);

    always_comb begin
        sel = '0;
        if (is_bram) begin
            sel[soc_pkg::SEL_BRAM] = 1'b1;
        end else if (is_uart) begin
            sel[soc_pkg::SEL_UART] = 1'b1;
        end else if (is_timer) begin
            sel[soc_pkg::SEL_TIMER] = 1'b1;
        end else if (is_sysinfo) begin
            sel[soc_pkg::SEL_SYSINFO] = 1'b1;
        end else begin
            sel[soc_pkg::SEL_UNMAPPED] = 1'b1;
        end
    end

    // no strobe while the response is on the bus, one strobe per request
    assign strobe = valid && !ready;

    assign bram_valid     = strobe && sel[soc_pkg::SEL_BRAM];
    assign uart_valid     = strobe && sel[soc_pkg::SEL_UART];
    assign timer_valid    = strobe && sel[soc_pkg::SEL_TIMER];
    assign sysinfo_valid  = strobe && sel[soc_pkg::SEL_SYSINFO];
    assign unmapped_valid = strobe && sel[soc_pkg::SEL_UNMAPPED];

    // the target answers, so its strobe lasts a single cycle
    a_one_strobe: assert property (@(posedge clk) disable iff (!resetn)
        strobe |=> !strobe);

endmodule

//--- bram/bram.sv
module bram #(
    parameter int BRAM_WORDS = 256
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              valid,
    input  soc_pkg::bus_req_t req,
    output logic              ready,
    output soc_pkg::data_t    rdata
);

    localparam int AW = $clog2(BRAM_WORDS);

    soc_pkg::data_t mem [BRAM_WORDS];
    logic [AW-1:0]  idx;

    // word index from the byte address
    assign idx = req.addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (valid) begin
            for (int i = 0; i < 4; i++) begin
                if (req.wstrb[i]) begin
                    mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
            // old word, read before write
            rdata <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ready <= 1'b0;
        end else begin
            ready <= valid;
        end
    end

endmodule

//--- uart/uart_tx.sv
module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       tx_busy,
    output logic       txd
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    soc_pkg::uart_state_t state;
    logic [CW-1:0]        clk_cnt;
    logic [2:0]           bit_idx;
    logic [7:0]           shift;
    logic                 bit_end;

    assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));
    assign tx_busy = (state != soc_pkg::UART_IDLE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= soc_pkg::UART_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                soc_pkg::UART_IDLE: begin
                    clk_cnt <= '0;
                    if (tx_start) begin
                        state <= soc_pkg::UART_START;
                        shift <= tx_byte;
                        txd   <= 1'b0;
                    end
                end
                soc_pkg::UART_START: begin
                    if (bit_end) begin
                        state   <= soc_pkg::UART_DATA;
                        bit_idx <= '0;
                        txd     <= shift[0];
                    end
                end
                soc_pkg::UART_DATA: begin
                    if (bit_end) begin
                        // lsb first
                        shift   <= shift >> 1;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= soc_pkg::UART_STOP;
                            txd   <= 1'b1;
                        end else begin
                            txd <= shift[1];
                        end
                    end
                end
                soc_pkg::UART_STOP: begin
                    if (bit_end) begin
                        state <= soc_pkg::UART_IDLE;
                    end
                end
                default: state <= soc_pkg::UART_IDLE;
            endcase
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (!resetn)
        state == soc_pkg::UART_IDLE |-> txd);

endmodule

//--- uart/uart_rx.sv
module uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       rxd,
    output logic       rx_done,
    output logic [7:0] rx_byte
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    soc_pkg::uart_state_t state;
    logic [CW-1:0]        clk_cnt;
    logic [2:0]           bit_idx;
    logic [7:0]           shift;
    logic                 rxd_meta;
    logic                 rxd_sync;
    logic                 bit_end;
    logic                 half_end;

    assign bit_end  = (clk_cnt == CW'(CLKS_PER_BIT - 1));
    assign half_end = (clk_cnt == CW'(CLKS_PER_BIT / 2 - 1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            state    <= soc_pkg::UART_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_done  <= 1'b0;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rx_done  <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                soc_pkg::UART_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_sync) begin
                        state <= soc_pkg::UART_START;
                    end
                end
                soc_pkg::UART_START: begin
                    // confirm start bit at its middle
                    if (half_end) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? soc_pkg::UART_IDLE : soc_pkg::UART_DATA;
                    end
                end
                soc_pkg::UART_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        shift   <= {rxd_sync, shift[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= soc_pkg::UART_STOP;
                        end
                    end
                end
                soc_pkg::UART_STOP: begin
                    if (bit_end) begin
                        state <= soc_pkg::UART_IDLE;
                        // framing error drops the byte
                        if (rxd_sync) begin
                            rx_done <= 1'b1;
                            rx_byte <= shift;
                        end
                    end
                end
                default: state <= soc_pkg::UART_IDLE;
            endcase
        end
    end

endmodule

//--- uart/uart_regs.sv
module uart_regs #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              valid,
    input  soc_pkg::bus_req_t req,
    output logic              ready,
    output soc_pkg::data_t    rdata,
    output logic              txd,
    input  logic              rxd
);

    logic           is_data;
    logic           is_lsr;
    logic           wr;
    logic           pop;
    logic           lsr_rd;
    logic           tx_go;
    logic           tx_start;
    logic [7:0]     tx_byte;
    logic           tx_busy;
    logic           rx_done;
    logic [7:0]     rx_byte;
    logic [7:0]     rx_hold;
    logic           rx_ready;
    logic           overrun;
    soc_pkg::data_t lsr;

    assign is_data = (req.addr == soc_pkg::UART_DATA_ADDR);
    assign is_lsr  = (req.addr == soc_pkg::UART_LSR_ADDR);
    assign wr      = |req.wstrb;
    assign pop     = valid && is_data && !wr;
    assign lsr_rd  = valid && is_lsr && !wr;
    // byte is dropped while the shifter is busy
    assign tx_go   = valid && is_data && wr && !tx_busy && !tx_start;

    always_comb begin
        lsr = '0;
        lsr[soc_pkg::LSR_RX_READY] = rx_ready;
        lsr[soc_pkg::LSR_OVERRUN]  = overrun;
        // no holding register, both track the shifter
        lsr[soc_pkg::LSR_TX_EMPTY] = !tx_busy && !tx_start;
        lsr[soc_pkg::LSR_TX_IDLE]  = !tx_busy && !tx_start;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ready    <= 1'b0;
            tx_start <= 1'b0;
            rx_ready <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            ready    <= valid;
            tx_start <= tx_go;
            if (rx_done) begin
                rx_ready <= 1'b1;
            end else if (pop) begin
                rx_ready <= 1'b0;
            end
            if (rx_done && rx_ready && !pop) begin
                overrun <= 1'b1;
            end else if (lsr_rd) begin
                overrun <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done) begin
            rx_hold <= rx_byte;
        end
        if (tx_go) begin
            tx_byte <= req.wdata[7:0];
        end
        rdata <= pop ? {24'h0, rx_hold} : (lsr_rd ? lsr : '0);
    end

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_tx (
        .clk     (clk),
        .resetn  (resetn),
        .tx_start(tx_start),
        .tx_byte (tx_byte),
        .tx_busy (tx_busy),
        .txd     (txd)
    );

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_rx (
        .clk    (clk),
        .resetn (resetn),
        .rxd    (rxd),
        .rx_done(rx_done),
        .rx_byte(rx_byte)
    );

    a_no_start_busy: assert property (@(posedge clk) disable iff (!resetn)
        tx_start |-> !tx_busy);

endmodule

//--- logic/timer.sv
module timer (
    input  logic              clk,
    input  logic              resetn,
    input  logic              valid,
    input  soc_pkg::bus_req_t req,
    output logic              ready,
    output soc_pkg::data_t    rdata,
    output logic              timer_irq
);

    logic [63:0]    count;
    logic [63:0]    compare;
    logic [1:0]     offset;
    logic           wr;
    soc_pkg::data_t cur_word;
    soc_pkg::data_t new_word;

    // byte-lane merge into the addressed half
    function automatic soc_pkg::data_t merge(soc_pkg::data_t old_word,
                                             soc_pkg::data_t wdata,
                                             soc_pkg::strb_t wstrb);
        soc_pkg::data_t res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (wstrb[i]) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign offset   = req.addr[3:2];
    assign wr       = |req.wstrb;
    assign new_word = merge(cur_word, req.wdata, req.wstrb);

    always_comb begin
        case (offset)
            2'd0:    cur_word = count[31:0];
            2'd1:    cur_word = count[63:32];
            2'd2:    cur_word = compare[31:0];
            default: cur_word = compare[63:32];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ready     <= 1'b0;
            count     <= '0;
            compare   <= '1;
            timer_irq <= 1'b0;
        end else begin
            ready     <= valid;
            count     <= count + 64'd1;
            timer_irq <= (count >= compare);
            if (valid && wr) begin
                case (offset)
                    2'd0:    count   <= {count[63:32], new_word};
                    2'd1:    count   <= {new_word, count[31:0]};
                    2'd2:    compare <= {compare[63:32], new_word};
                    default: compare <= {new_word, compare[31:0]};
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            rdata <= cur_word;
        end
    end

endmodule

//--- logic/response_mux.sv
module response_mux #(
    parameter int CLK_HZ = 50_000_000
) (
    input  logic           clk,
    input  logic           resetn,
    input  logic           sysinfo_valid,
    input  logic           unmapped_valid,
    input  logic           bram_ready,
    input  logic           uart_ready,
    input  logic           timer_ready,
    input  soc_pkg::data_t bram_rdata,
    input  soc_pkg::data_t uart_rdata,
    input  soc_pkg::data_t timer_rdata,
    output logic           ready,
    output soc_pkg::data_t rdata,
    output logic           access_fault
);

    logic sysinfo_ready;
    logic unmapped_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            sysinfo_ready  <= 1'b0;
            unmapped_ready <= 1'b0;
        end else begin
            sysinfo_ready  <= sysinfo_valid;
            unmapped_ready <= unmapped_valid;
        end
    end

    assign ready = bram_ready || uart_ready || timer_ready ||
                   sysinfo_ready || unmapped_ready;

    // unmapped falls through to zero
    assign rdata = bram_ready    ? bram_rdata  :
                   uart_ready    ? uart_rdata  :
                   timer_ready   ? timer_rdata :
                   sysinfo_ready ? soc_pkg::data_t'(CLK_HZ) :
                   '0;

    assign access_fault = unmapped_ready;

    a_one_ready: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0({bram_ready, uart_ready, timer_ready, sysinfo_ready, unmapped_ready}));

endmodule

//--- logic/soc_bus.sv
module soc_bus #(
    parameter int BRAM_WORDS   = 256,
    parameter int CLK_HZ       = 50_000_000,
    parameter int CLKS_PER_BIT = 8
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              valid,
    input  soc_pkg::bus_req_t req,
    output logic              ready,
    output soc_pkg::data_t    rdata,
    output logic              access_fault,
    output logic              uart_txd,
    input  logic              uart_rxd,
    output logic              timer_irq
);

    logic           bram_valid;
    logic           uart_valid;
    logic           timer_valid;
    logic           sysinfo_valid;
    logic           unmapped_valid;
    logic           bram_ready;
    logic           uart_ready;
    logic           timer_ready;
    soc_pkg::data_t bram_rdata;
    soc_pkg::data_t uart_rdata;
    soc_pkg::data_t timer_rdata;

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    bus_decoder #(
        .BRAM_WORDS(BRAM_WORDS)
    ) u_bus_decoder (
        .clk           (clk),
        .resetn        (resetn),
        .valid         (valid),
        .req           (req),
        .ready         (ready),
        .sel           (),
        .bram_valid    (bram_valid),
        .uart_valid    (uart_valid),
        .timer_valid   (timer_valid),
        .sysinfo_valid (sysinfo_valid),
        .unmapped_valid(unmapped_valid)
    );

    ////////////////////////////////////////
    // targets
    ////////////////////////////////////////
    bram #(
        .BRAM_WORDS(BRAM_WORDS)
    ) u_bram (
        .clk   (clk),
        .resetn(resetn),
        .valid (bram_valid),
        .req   (req),
        .ready (bram_ready),
        .rdata (bram_rdata)
    );

    uart_regs #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_regs (
        .clk   (clk),
        .resetn(resetn),
        .valid (uart_valid),
        .req   (req),
        .ready (uart_ready),
        .rdata (uart_rdata),
        .txd   (uart_txd),
        .rxd   (uart_rxd)
    );

    timer u_timer (
        .clk      (clk),
        .resetn   (resetn),
        .valid    (timer_valid),
        .req      (req),
        .ready    (timer_ready),
        .rdata    (timer_rdata),
        .timer_irq(timer_irq)
    );

    ////////////////////////////////////////
    // response
    ////////////////////////////////////////
    response_mux #(
        .CLK_HZ(CLK_HZ)
    ) u_response_mux (
        .clk           (clk),
        .resetn        (resetn),
        .sysinfo_valid (sysinfo_valid),
        .unmapped_valid(unmapped_valid),
        .bram_ready    (bram_ready),
        .uart_ready    (uart_ready),
        .timer_ready   (timer_ready),
        .bram_rdata    (bram_rdata),
        .uart_rdata    (uart_rdata),
        .timer_rdata   (timer_rdata),
        .ready         (ready),
        .rdata         (rdata),
        .access_fault  (access_fault)
    );

endmodule

//--- dv/tb_soc_bus.sv
module tb_soc_bus;

    localparam int CLKS_PER_BIT = 8;
    localparam int BRAM_WORDS   = 256;
    localparam int CLK_HZ       = 50_000_000;
    localparam int MAX_PAT      = 64;
    localparam int RESET_CYCLES = 8;
    localparam int LATE_LIMIT   = 16;
    localparam int POLL_LIMIT   = 200;

    logic              clk;
    logic              resetn;
    logic              valid;
    soc_pkg::bus_req_t req;
    logic              ready;
    soc_pkg::data_t    rdata;
    logic              access_fault;
    logic              uart_loop;
    logic              timer_irq;

    // five words per record: op, addr, wdata, wstrb, expected
    logic [31:0] pat [0:5*MAX_PAT-1];
    int          n_pat;
    int          n_checks;
    int          n_errors;
    int          cur_pat;
    logic        loaded;

    soc_bus #(
        .BRAM_WORDS  (BRAM_WORDS),
        .CLK_HZ      (CLK_HZ),
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_soc_bus (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .req         (req),
        .ready       (ready),
        .rdata       (rdata),
        .access_fault(access_fault),
        .uart_txd    (uart_loop),
        .uart_rxd    (uart_loop),
        .timer_irq   (timer_irq)
    );

    always #4 clk = ~clk;

    // address map regions, unmapped when none match
    function automatic logic expect_fault(soc_pkg::addr_t addr);
        logic mapped;
        mapped = (addr >= soc_pkg::BRAM_BASE && addr < soc_pkg::BRAM_BASE + BRAM_WORDS * 4) ||
                 addr == soc_pkg::UART_DATA_ADDR || addr == soc_pkg::UART_LSR_ADDR ||
                 (addr >= soc_pkg::TIMER_BASE && addr < soc_pkg::TIMER_BASE + 16) ||
                 addr == soc_pkg::SYSINFO_ADDR;
        return !mapped;
    endfunction

    task automatic check_value(input string what, input soc_pkg::data_t exp,
                               input soc_pkg::data_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAILED pattern %0d %s: expected %h, actual %h", cur_pat, what, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // bus master
    ////////////////////////////////////////
    task automatic bus_access(input soc_pkg::addr_t addr, input soc_pkg::data_t wdata,
                              input soc_pkg::strb_t wstrb, output soc_pkg::data_t rd);
        int waited;
        waited = 0;
        @(negedge clk);
        valid      = 1'b1;
        req.addr   = addr;
        req.wdata  = wdata;
        req.wstrb  = wstrb;
        @(negedge clk);
        // ready due exactly one cycle after valid
        n_checks++;
        if (!ready) begin
            n_errors++;
            $display("pattern %0d: no ready one cycle after valid, address %h", cur_pat, addr);
            while (!ready && waited < LATE_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (ready) begin
                $display("pattern %0d: ready came %0d cycles late", cur_pat, waited);
            end else begin
                $display("pattern %0d: ready never came", cur_pat);
            end
        end
        rd = rdata;
        check_value("access_fault", soc_pkg::data_t'(expect_fault(addr)),
                    soc_pkg::data_t'(access_fault));
        valid = 1'b0;
        req   = '0;
    endtask

    task automatic run_pattern(input logic [31:0] op, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [31:0] wstrb,
                               input logic [31:0] exp);
        soc_pkg::data_t rd;
        int             polls;
        rd    = '0;
        polls = 0;
        case (op)
            0: begin
                bus_access(addr, wdata, wstrb[3:0], rd);
                check_value("rdata", exp, rd);
            end
            1: bus_access(addr, wdata, wstrb[3:0], rd);
            2: begin
                // wait for the looped-back byte
                while (!rd[soc_pkg::LSR_RX_READY] && polls < POLL_LIMIT) begin
                    bus_access(soc_pkg::UART_LSR_ADDR, '0, '0, rd);
                    polls++;
                end
                if (!rd[soc_pkg::LSR_RX_READY]) begin
                    n_errors++;
                    $display("pattern %0d: receive byte never became ready", cur_pat);
                end
                bus_access(addr, '0, '0, rd);
                check_value("rx data", exp, rd);
            end
            3: begin
                @(posedge clk);
                @(negedge clk);
                check_value("timer_irq", exp, {31'h0, timer_irq});
            end
            default: begin
                n_errors++;
                $display("pattern %0d: unknown op %h", cur_pat, op);
            end
        endcase
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////
    initial begin
        clk      = 1'b0;
        resetn   = 1'b0;
        valid    = 1'b0;
        req      = '0;
        n_pat    = 0;
        n_checks = 0;
        n_errors = 0;
        cur_pat  = 0;
        loaded   = 1'b0;
        $readmemh("dv/bus_patterns.txt", pat);
        // op f ends the list
        while (n_pat < MAX_PAT && pat[5*n_pat] != 32'hf) begin
            n_pat++;
        end
        loaded = 1'b1;
        if (n_pat == 0) begin
            n_errors++;
            $display("no patterns found in dv/bus_patterns.txt");
        end
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;
        for (int i = 0; i < n_pat; i++) begin
            cur_pat = i;
            run_pattern(pat[5*i], pat[5*i+1], pat[5*i+2], pat[5*i+3], pat[5*i+4]);
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (RESET_CYCLES + n_pat * 20 * CLKS_PER_BIT) @(posedge clk);
        $display("timeout: run did not finish in %0d cycles",
                 RESET_CYCLES + n_pat * 20 * CLKS_PER_BIT);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- dv/bus_patterns.txt
// columns: op addr wdata wstrb expected (hex)
// op 0 access and check, 1 access only, 2 wait rx ready then read, 3 check timer_irq, f end
// bram byte masking
1 00000010 11223344 f 00000000
0 00000010 0000ab00 2 11223344
0 00000010 00000000 0 1122ab44
1 000003fc cafef00d f 00000000
0 000003fc 00000000 0 cafef00d
// uart loopback
0 10000004 00000000 0 00000060
1 10000000 000000a5 1 00000000
2 10000000 00000000 0 000000a5
0 10000004 00000000 0 00000060
// timer compare
3 00000000 00000000 0 00000000
0 11000008 00000000 0 ffffffff
0 1100000c 00000000 0 ffffffff
1 11000008 00000000 f 00000000
1 1100000c 00000000 f 00000000
3 00000000 00000000 0 00000001
0 11000008 00000000 0 00000000
1 1100000c ffffffff f 00000000
1 11000008 ffffffff f 00000000
3 00000000 00000000 0 00000000
// sysinfo and unmapped
0 12000000 00000000 0 02faf080
0 20000000 00000000 0 00000000
0 00000400 00000000 0 00000000
0 11000010 00000000 0 00000000
f 00000000 00000000 0 00000000

//--- src.f
common/soc_pkg.sv
logic/bus_decoder.sv
bram/bram.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_regs.sv
logic/timer.sv
logic/response_mux.sv
logic/soc_bus.sv
dv/tb_soc_bus.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_soc_bus
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
